//--- hw/mbxPkg.sv
package mbxPkg;

  //////////////////////////////////////////////////////////////////////
  // Line geometry
  //////////////////////////////////////////////////////////////////////

  localparam int NumWords = 4;

  typedef logic [1:0] wordIdx_t;
  typedef logic [NumWords-1:0] wordMask_t;

  // Source code kept with each buffered word
  typedef logic [1:0] dataCode_t;

  typedef struct packed {
    logic par;
    dataCode_t code;
  } mbWord_t;

  //////////////////////////////////////////////////////////////////////
  // Commands
  //////////////////////////////////////////////////////////////////////

  typedef logic [1:0] cmdOp_t;

  localparam cmdOp_t OpLineRead = 2'd1;
  localparam cmdOp_t OpWordRead = 2'd2;
  localparam cmdOp_t OpFlush = 2'd3;

  typedef struct packed {
    cmdOp_t op;
    wordIdx_t idx;
    wordMask_t validMask;
    wordMask_t neededMask;
  } mbCmd_t;

  // Core store into one buffer slot
  typedef struct packed {
    wordIdx_t idx;
    mbWord_t word;
  } mbStore_t;

  // Memory side of the buffer
  typedef struct packed {
    logic write;
    wordIdx_t sel;
    mbWord_t word;
  } mbMemReq_t;

endpackage

//--- hw/mbRequestGen.sv
`timescale 1ns/1ps

module mbRequestGen
  import mbxPkg::*;
(
  input mbCmd_t cmd,
  input logic cmdValid,
  input logic busy,
  input wordMask_t dirty,
  output logic load,
  output wordMask_t loadMask,
  output logic loadWrite
);

  wordMask_t missing;
  wordMask_t wordHot;
  wordMask_t reqMask;

  //////////////////////////////////////////////////////////////////////
  // Word request mask
  //////////////////////////////////////////////////////////////////////

  // Words the line still needs and the cache does not hold
  assign missing = cmd.neededMask & ~cmd.validMask;

  assign wordHot = wordMask_t'(1) << cmd.idx;

  always_comb begin
    case (cmd.op)
      OpLineRead: begin
        reqMask = missing;
      end
      OpWordRead: begin
        reqMask = wordHot;
      end
      OpFlush: begin
        reqMask = dirty;
      end
      default: begin
        reqMask = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Load into the pending register
  //////////////////////////////////////////////////////////////////////

  // Empty mask or op 0 is accepted but loads nothing
  assign load = cmdValid & ~busy & (|reqMask);
  assign loadMask = reqMask;
  assign loadWrite = (cmd.op == OpFlush);

endmodule

//--- hw/mbWordRequest.sv
`timescale 1ns/1ps

module mbWordRequest
  import mbxPkg::*;
(
  input logic clk,
  input logic rst,

  input logic load,
  input wordMask_t loadMask,
  input logic loadWrite,

  input logic memAck,

  output logic busy,
  output logic memReq,
  output logic write,
  output wordIdx_t sel,
  output logic ackRead,
  output logic ackWrite
);

  wordMask_t pending;
  wordMask_t pendingNext;
  logic writeFlag;
  logic writeNext;
  logic ackAny;

  // Lowest set bit wins
  function automatic wordIdx_t lowestIdx(input wordMask_t mask);
    wordIdx_t idx;
    idx = '0;
    for (int i = NumWords - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = wordIdx_t'(i);
      end
    end
    return idx;
  endfunction

  assign memReq = |pending;
  assign busy = memReq;
  assign write = writeFlag;

  // Acks outside a request are dropped
  assign ackAny = memAck & memReq;
  assign ackRead = ackAny & ~writeFlag;
  assign ackWrite = ackAny & writeFlag;

  //////////////////////////////////////////////////////////////////////
  // Pending words
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pendingNext = pending;
    writeNext = writeFlag;
    if (load) begin
      pendingNext = loadMask;
      writeNext = loadWrite;
    end else if (ackAny) begin
      // Only the selected word is retired
      pendingNext = pending & ~(wordMask_t'(1) << sel);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
      writeFlag <= 1'b0;
    end else begin
      pending <= pendingNext;
      writeFlag <= writeNext;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Select hold
  //////////////////////////////////////////////////////////////////////

  // Select moves only on a new load or an ack, so memory sees it stable
  always_ff @(posedge clk) begin
    if (rst) begin
      sel <= '0;
    end else if (load || ackAny) begin
      sel <= lowestIdx(pendingNext);
    end
  end

  // Held select must still point at a word that is owed
  selPending: assert property (
    @(posedge clk) disable iff (rst)
    memReq |-> pending[sel]
  );

  // Request side must wait for the previous line to drain
  noLoadBusy: assert property (
    @(posedge clk) disable iff (rst)
    load |-> !busy
  );

endmodule

//--- hw/mbSlotStore.sv
`timescale 1ns/1ps

module mbSlotStore
  import mbxPkg::*;
#(
  parameter bit AckClearsDirty = 1'b1
) (
  input logic clk,
  input logic rst,

  input logic storeValid,
  input logic storeReady,
  input mbStore_t store,

  input wordIdx_t sel,
  input logic ackRead,
  input logic ackWrite,
  input mbWord_t memRdWord,

  input wordIdx_t peekIdx,

  output mbWord_t selWord,
  output mbWord_t peekWord,
  output wordMask_t dirty
);

  mbWord_t slots [NumWords];
  logic storeFire;

  assign storeFire = storeValid & storeReady;

  //////////////////////////////////////////////////////////////////////
  // Buffer slots
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NumWords; i++) begin
        slots[i] <= '0;
      end
    end else if (storeFire) begin
      slots[store.idx] <= store.word;
    end else if (ackRead) begin
      // Memory data lands in the word it was fetched for
      slots[sel] <= memRdWord;
    end
  end

  // Dirty mask set by core stores and cleared by flush acks
  always_ff @(posedge clk) begin
    if (rst) begin
      dirty <= '0;
    end else if (storeFire) begin
      dirty[store.idx] <= 1'b1;
    end else if (ackWrite && AckClearsDirty) begin
      dirty[sel] <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output muxes
  //////////////////////////////////////////////////////////////////////

  assign selWord = slots[sel];
  assign peekWord = slots[peekIdx];

  // Stores are only taken while no word is owed to memory
  storeNoAck: assert property (
    @(posedge clk) disable iff (rst)
    storeFire |-> !(ackRead || ackWrite)
  );

endmodule

//--- hw/mbxTop.sv
`timescale 1ns/1ps

module mbxTop
  import mbxPkg::*;
#(
  parameter bit AckClearsDirty = 1'b1
) (
  input logic clk,
  input logic rst,

  input mbCmd_t cmd,
  input logic cmdValid,
  output logic cmdReady,

  input mbStore_t store,
  input logic storeValid,
  output logic storeReady,

  output logic memReq,
  output mbMemReq_t mem,
  input logic memAck,
  input mbWord_t memRdWord,

  input wordIdx_t peekIdx,
  output mbWord_t peekWord,
  output wordMask_t dirty
);

  logic load;
  wordMask_t loadMask;
  logic loadWrite;
  logic busy;
  logic reqWrite;
  wordIdx_t sel;
  logic ackRead;
  logic ackWrite;
  mbWord_t selWord;

  // Core side may only talk to the buffer while nothing is pending
  assign cmdReady = ~busy;
  assign storeReady = ~busy;

  assign mem = '{write: reqWrite, sel: sel, word: selWord};

  mbRequestGen mbRequestGen_i (
    .cmd(cmd),
    .cmdValid(cmdValid),
    .busy(busy),
    .dirty(dirty),
    .load(load),
    .loadMask(loadMask),
    .loadWrite(loadWrite)
  );

  mbWordRequest mbWordRequest_i (
    .clk(clk),
    .rst(rst),
    .load(load),
    .loadMask(loadMask),
    .loadWrite(loadWrite),
    .memAck(memAck),
    .busy(busy),
    .memReq(memReq),
    .write(reqWrite),
    .sel(sel),
    .ackRead(ackRead),
    .ackWrite(ackWrite)
  );

  mbSlotStore #(
    .AckClearsDirty(AckClearsDirty)
  ) mbSlotStore_i (
    .clk(clk),
    .rst(rst),
    .storeValid(storeValid),
    .storeReady(storeReady),
    .store(store),
    .sel(sel),
    .ackRead(ackRead),
    .ackWrite(ackWrite),
    .memRdWord(memRdWord),
    .peekIdx(peekIdx),
    .selWord(selWord),
    .peekWord(peekWord),
    .dirty(dirty)
  );

endmodule

//--- verification/mbxTbModel.svh
`ifndef MBX_TB_MODEL_SVH
`define MBX_TB_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model of the buffer
//////////////////////////////////////////////////////////////////////

mbWord_t modelSlots [NumWords];
wordMask_t modelDirty;
wordMask_t modelPending;
logic modelWrite;

task automatic resetModel();
  for (int i = 0; i < NumWords; i++) begin
    modelSlots[i] = '0;
  end
  modelDirty = '0;
  modelPending = '0;
  modelWrite = 1'b0;
endtask

// Words a command asks memory for
function automatic wordMask_t requestMask(input mbCmd_t c);
  wordMask_t m;
  m = '0;
  if (c.op == OpLineRead) begin
    m = c.neededMask & ~c.validMask;
  end else if (c.op == OpWordRead) begin
    m[c.idx] = 1'b1;
  end else if (c.op == OpFlush) begin
    m = modelDirty;
  end
  return m;
endfunction

// Memory is served lowest index first
function automatic wordIdx_t lowestPending(input wordMask_t m);
  wordIdx_t idx;
  logic found;
  idx = '0;
  found = 1'b0;
  for (int i = 0; i < NumWords; i++) begin
    if (m[i] && !found) begin
      idx = wordIdx_t'(i);
      found = 1'b1;
    end
  end
  return idx;
endfunction

task automatic applyStore(input mbStore_t s);
  modelSlots[s.idx] = s.word;
  modelDirty[s.idx] = 1'b1;
endtask

task automatic applyCommand(input mbCmd_t c);
  modelPending = requestMask(c);
  modelWrite = (c.op == OpFlush);
endtask

task automatic retireWord(input mbWord_t rd);
  wordIdx_t idx;
  idx = lowestPending(modelPending);
  if (modelWrite) begin
    modelDirty[idx] = 1'b0;
  end else begin
    modelSlots[idx] = rd;
  end
  modelPending[idx] = 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic stopOnError(input string what);
  $display("%s", what);
  $display("Regression failed");
  $fatal(1, "stopped at first error");
endtask

task automatic checkWord(input string name, input mbWord_t expected, input mbWord_t actual);
  if (actual !== expected) begin
    stopOnError($sformatf("mismatch at %0t: %s expected %h actual %h",
                          $time, name, expected, actual));
  end
endtask

task automatic checkMask(input string name, input wordMask_t expected,
                         input wordMask_t actual);
  if (actual !== expected) begin
    stopOnError($sformatf("mismatch at %0t: %s expected %b actual %b",
                          $time, name, expected, actual));
  end
endtask

task automatic checkIdx(input string name, input wordIdx_t expected, input wordIdx_t actual);
  if (actual !== expected) begin
    stopOnError($sformatf("mismatch at %0t: %s expected %0d actual %0d",
                          $time, name, expected, actual));
  end
endtask

task automatic checkBit(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    stopOnError($sformatf("mismatch at %0t: %s expected %b actual %b",
                          $time, name, expected, actual));
  end
endtask

`endif

//--- verification/mbxTb.sv
`timescale 1ns/1ps

module mbxTb
  import mbxPkg::*;
();

  localparam int NumTrans = 80;
  localparam int WatchdogCycles = NumTrans * 40 + 100;
  localparam int ReadyLimit = 20;

  logic clk;
  logic rst;
  mbCmd_t cmd;
  logic cmdValid;
  logic cmdReady;
  mbStore_t store;
  logic storeValid;
  logic storeReady;
  logic memReq;
  mbMemReq_t mem;
  logic memAck;
  mbWord_t memRdWord;
  wordIdx_t peekIdx;
  mbWord_t peekWord;
  wordMask_t dirty;
  integer seed;

  `include "mbxTbModel.svh"

  mbxTop #(
    .AckClearsDirty(1'b1)
  ) mbxTop_i (
    .clk(clk),
    .rst(rst),
    .cmd(cmd),
    .cmdValid(cmdValid),
    .cmdReady(cmdReady),
    .store(store),
    .storeValid(storeValid),
    .storeReady(storeReady),
    .memReq(memReq),
    .mem(mem),
    .memAck(memAck),
    .memRdWord(memRdWord),
    .peekIdx(peekIdx),
    .peekWord(peekWord),
    .dirty(dirty)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    return $random(seed);
  endfunction

  function automatic mbWord_t randomWord();
    logic [31:0] r;
    mbWord_t w;
    r = nextRandom();
    w = r[2:0];
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Transaction tasks
  //////////////////////////////////////////////////////////////////////

  // Ends on a falling edge with the core port ready
  task automatic waitForReady();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!cmdReady) begin
      waited++;
      if (waited > ReadyLimit) begin
        stopOnError("command port never became ready");
      end
      @(negedge clk);
    end
  endtask

  task automatic runStore(input mbStore_t s);
    waitForReady();
    @(posedge clk);
    store <= s;
    storeValid <= 1'b1;
    peekIdx <= s.idx;
    @(posedge clk);
    storeValid <= 1'b0;
    applyStore(s);
    @(negedge clk);
    checkMask("dirty", modelDirty, dirty);
    checkWord("peekWord", modelSlots[s.idx], peekWord);
  endtask

  task automatic sweepSlots();
    for (int i = 0; i < NumWords; i++) begin
      @(posedge clk);
      peekIdx <= wordIdx_t'(i);
      @(negedge clk);
      checkWord($sformatf("peekWord[%0d]", i), modelSlots[i], peekWord);
    end
  endtask

  // An acknowledge with nothing pending must change nothing
  task automatic strayAck();
    waitForReady();
    @(posedge clk);
    memAck <= 1'b1;
    memRdWord <= randomWord();
    @(posedge clk);
    memAck <= 1'b0;
    @(negedge clk);
    checkBit("memReq", 1'b0, memReq);
    checkBit("cmdReady", 1'b1, cmdReady);
    checkMask("dirty", modelDirty, dirty);
    sweepSlots();
  endtask

  task automatic runCommand(input mbCmd_t c);
    wordIdx_t expSel;
    mbWord_t heldWord;
    mbWord_t rdWord;
    int delay;
    waitForReady();
    @(posedge clk);
    cmd <= c;
    cmdValid <= 1'b1;
    @(posedge clk);
    cmdValid <= 1'b0;
    applyCommand(c);
    @(negedge clk);
    while (modelPending != '0) begin
      expSel = lowestPending(modelPending);
      checkBit("memReq", 1'b1, memReq);
      checkBit("cmdReady", 1'b0, cmdReady);
      checkBit("storeReady", 1'b0, storeReady);
      checkBit("mem.write", modelWrite, mem.write);
      checkIdx("mem.sel", expSel, mem.sel);
      if (modelWrite) begin
        checkWord("mem.word", modelSlots[expSel], mem.word);
      end
      heldWord = mem.word;
      // Memory holds off for a while and the request must not move
      delay = nextRandom() & 7;
      repeat (delay) begin
        @(negedge clk);
        checkIdx("mem.sel", expSel, mem.sel);
        checkWord("mem.word", heldWord, mem.word);
        checkBit("cmdReady", 1'b0, cmdReady);
      end
      rdWord = randomWord();
      @(posedge clk);
      memAck <= 1'b1;
      memRdWord <= rdWord;
      peekIdx <= expSel;
      @(posedge clk);
      memAck <= 1'b0;
      memRdWord <= randomWord();
      retireWord(rdWord);
      @(negedge clk);
      checkMask("dirty", modelDirty, dirty);
      checkWord("peekWord", modelSlots[expSel], peekWord);
    end
    checkBit("memReq", 1'b0, memReq);
    checkBit("cmdReady", 1'b1, cmdReady);
    checkBit("storeReady", 1'b1, storeReady);
    if (c.op == OpFlush) begin
      checkMask("dirty", wordMask_t'(0), dirty);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    mbCmd_t c;
    mbStore_t s;
    clk = 1'b0;
    rst = 1'b1;
    cmd = '0;
    cmdValid = 1'b0;
    store = '0;
    storeValid = 1'b0;
    memAck = 1'b0;
    memRdWord = '0;
    peekIdx = '0;
    seed = 32'h62ef_e9ab;
    resetModel();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkBit("cmdReady", 1'b1, cmdReady);
    checkBit("storeReady", 1'b1, storeReady);
    checkBit("memReq", 1'b0, memReq);
    checkMask("dirty", wordMask_t'(0), dirty);
    sweepSlots();

    for (int t = 0; t < NumTrans; t++) begin
      r = nextRandom();
      if (t < NumWords || r[2:0] < 3'd3) begin
        s.idx = (t < NumWords) ? wordIdx_t'(t) : r[9:8];
        s.word = randomWord();
        runStore(s);
      end else if (r[2:0] == 3'd7) begin
        strayAck();
      end else begin
        c.op = r[5:4];
        c.idx = r[9:8];
        c.validMask = r[15:12];
        c.neededMask = r[19:16];
        runCommand(c);
      end
      if (t % 8 == 7) begin
        sweepSlots();
      end
    end
    sweepSlots();

    $display("Regression passed");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: the transactions did not finish in %0d cycles", WatchdogCycles);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- compile.f
+incdir+verification
hw/mbxPkg.sv
hw/mbRequestGen.sv
hw/mbWordRequest.sv
hw/mbSlotStore.sv
hw/mbxTop.sv
verification/mbxTb.sv
